// ==== vid_regs_pkg.sv ====
// Video register map
package vid_regs_pkg;

    // cpu bus fields
    typedef logic [15:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    // active low byte enables, bit 1 is the upper byte
    typedef logic [1:0]  be_n_t;
    typedef logic [7:0]  in_port_t;

    // A chip word offsets
    localparam reg_addr_t A_VRAM_OBJ   = 5'h00;
    localparam reg_addr_t A_VRAM1      = 5'h01;
    localparam reg_addr_t A_VRAM2      = 5'h02;
    localparam reg_addr_t A_VRAM3      = 5'h03;
    localparam reg_addr_t A_ROW_BASE   = 5'h04;
    localparam reg_addr_t A_PAL_BASE   = 5'h05;
    localparam reg_addr_t A_HPOS1      = 5'h06;
    localparam reg_addr_t A_VPOS1      = 5'h07;
    localparam reg_addr_t A_HPOS2      = 5'h08;
    localparam reg_addr_t A_VPOS2      = 5'h09;
    localparam reg_addr_t A_HPOS3      = 5'h0A;
    localparam reg_addr_t A_VPOS3      = 5'h0B;
    localparam reg_addr_t A_HSTAR1     = 5'h0C;
    localparam reg_addr_t A_VSTAR1     = 5'h0D;
    localparam reg_addr_t A_HSTAR2     = 5'h0E;
    localparam reg_addr_t A_VSTAR2     = 5'h0F;
    localparam reg_addr_t A_ROW_OFFSET = 5'h10;
    localparam reg_addr_t A_PPU_CTRL   = 5'h11;

    // default layer order after reset
    localparam word_t LAYER_CTRL_RST = 16'h0E40;
    // all six palette pages on
    localparam logic [5:0] PAL_PAGE_RST = 6'h3F;
    // returned when no register is hit
    localparam word_t IDLE_READ = 16'hFFFF;

endpackage

// ==== vid_cfg_pkg.sv ====
// Game configuration layout
package vid_cfg_pkg;

    localparam int CFG_BYTES = 14;

    // byte positions, byte 0 is shifted in first
    localparam int CFG_ID_ADDR  = 0;
    localparam int CFG_ID_VAL   = 1;
    localparam int CFG_MULT1    = 2;
    localparam int CFG_MULT2    = 3;
    localparam int CFG_RSLT0    = 4;
    localparam int CFG_RSLT1    = 5;
    localparam int CFG_LAYER    = 6;
    localparam int CFG_PRIO0    = 7;
    localparam int CFG_PRIO1    = 8;
    localparam int CFG_PRIO2    = 9;
    localparam int CFG_PRIO3    = 10;
    localparam int CFG_PAL_PAGE = 11;
    localparam int CFG_IN2      = 12;
    localparam int CFG_IN3      = 13;

    // multiplier and priority registers off at all ones, input ports off at zero
    localparam vid_regs_pkg::reg_addr_t ADDR_OFF_ONES = 5'h1F;
    localparam vid_regs_pkg::reg_addr_t ADDR_OFF_ZERO = 5'h00;

    // one-hot B register select, id in bit 0 up to in3 in bit 12
    typedef logic [12:0] b_sel_t;

endpackage

// ==== cfg_shift.sv ====
// Configuration shift register
`timescale 1ns/100ps

module cfg_shift (
    input  logic                      clk,
    input  logic                      cfg_we,
    input  vid_regs_pkg::in_port_t    cfg_data,
    input  logic                      busy,
    output vid_regs_pkg::reg_addr_t   addr_id, addr_mult1, addr_mult2,
    output vid_regs_pkg::reg_addr_t   addr_rslt0, addr_rslt1, addr_layer,
    output vid_regs_pkg::reg_addr_t   addr_prio0, addr_prio1, addr_prio2, addr_prio3,
    output vid_regs_pkg::reg_addr_t   addr_pal_page, addr_in2, addr_in3,
    output vid_regs_pkg::in_port_t    cpsb_id,
    output logic                      six_button
);

    vid_regs_pkg::in_port_t [vid_cfg_pkg::CFG_BYTES-1:0] cfg_q;

    // new byte enters at the top, the oldest one ends up in byte 0
    always_ff @(posedge clk) begin
        if (cfg_we) begin
            cfg_q <= {cfg_data, cfg_q[vid_cfg_pkg::CFG_BYTES-1:1]};
        end
    end

    // byte addresses, drop bit 0 to get the word address
    assign addr_id       = cfg_q[vid_cfg_pkg::CFG_ID_ADDR][5:1];
    assign addr_mult1    = cfg_q[vid_cfg_pkg::CFG_MULT1][5:1];
    assign addr_mult2    = cfg_q[vid_cfg_pkg::CFG_MULT2][5:1];
    assign addr_rslt0    = cfg_q[vid_cfg_pkg::CFG_RSLT0][5:1];
    assign addr_rslt1    = cfg_q[vid_cfg_pkg::CFG_RSLT1][5:1];
    assign addr_layer    = cfg_q[vid_cfg_pkg::CFG_LAYER][5:1];
    assign addr_prio0    = cfg_q[vid_cfg_pkg::CFG_PRIO0][5:1];
    assign addr_prio1    = cfg_q[vid_cfg_pkg::CFG_PRIO1][5:1];
    assign addr_prio2    = cfg_q[vid_cfg_pkg::CFG_PRIO2][5:1];
    assign addr_prio3    = cfg_q[vid_cfg_pkg::CFG_PRIO3][5:1];
    assign addr_pal_page = cfg_q[vid_cfg_pkg::CFG_PAL_PAGE][5:1];
    assign addr_in2      = cfg_q[vid_cfg_pkg::CFG_IN2][5:1];
    assign addr_in3      = cfg_q[vid_cfg_pkg::CFG_IN3][5:1];
    assign cpsb_id       = cfg_q[vid_cfg_pkg::CFG_ID_VAL];
    // top bit of the in2 address byte picks the six button layout
    assign six_button    = cfg_q[vid_cfg_pkg::CFG_IN2][7];

    // the map must not change under a running bus access
    cfg_idle_bus: assert property (@(posedge clk) busy |-> !cfg_we);

endmodule

// ==== bus_decode.sv ====
// Bus handshake and address decode
`timescale 1ns/100ps

module bus_decode (
    input  logic                      clk,
    input  logic                      reg_rst,
    input  logic                      req,
    input  logic                      chip,
    input  vid_regs_pkg::reg_addr_t   addr,
    input  vid_regs_pkg::be_n_t       be_n,
    input  vid_regs_pkg::reg_addr_t   addr_id, addr_mult1, addr_mult2,
    input  vid_regs_pkg::reg_addr_t   addr_rslt0, addr_rslt1, addr_layer,
    input  vid_regs_pkg::reg_addr_t   addr_prio0, addr_prio1, addr_prio2, addr_prio3,
    input  vid_regs_pkg::reg_addr_t   addr_pal_page, addr_in2, addr_in3,
    output logic                      ack,
    output logic                      strobe,
    output logic                      a_wr,
    output logic                      b_wr,
    output vid_cfg_pkg::b_sel_t       b_sel,
    output logic                      req_released
);

    typedef enum logic [1:0] {st_idle, st_busy, st_hold} state_t;

    state_t state;

    function automatic logic hit(input vid_regs_pkg::reg_addr_t a,
                                 input vid_regs_pkg::reg_addr_t cfg_addr,
                                 input vid_regs_pkg::reg_addr_t off_code);
        hit = (a == cfg_addr) && (cfg_addr != off_code);
    endfunction

    // access finished, cpu has let go of req
    assign req_released = (state == st_hold) && ack && !req;

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            state  <= st_idle;
            strobe <= 1'b0;
            ack    <= 1'b0;
        end else begin
            strobe <= (state == st_busy);
            case (state)
                st_idle: if (req && !ack) state <= st_busy;
                st_busy: state <= st_hold;
                st_hold: begin
                    if (strobe) begin
                        ack <= 1'b1;
                    end else if (req_released) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign a_wr = strobe && !chip && (be_n != 2'b11);
    assign b_wr = strobe && chip && (be_n != 2'b11);

    // an all ones address never hits a B register
    assign b_sel = (&addr) ? '0 : {
        hit(addr, addr_in3, vid_cfg_pkg::ADDR_OFF_ZERO),
        hit(addr, addr_in2, vid_cfg_pkg::ADDR_OFF_ZERO),
        addr == addr_pal_page,
        hit(addr, addr_prio3, vid_cfg_pkg::ADDR_OFF_ONES),
        hit(addr, addr_prio2, vid_cfg_pkg::ADDR_OFF_ONES),
        hit(addr, addr_prio1, vid_cfg_pkg::ADDR_OFF_ONES),
        hit(addr, addr_prio0, vid_cfg_pkg::ADDR_OFF_ONES),
        addr == addr_layer,
        hit(addr, addr_rslt1, vid_cfg_pkg::ADDR_OFF_ONES),
        hit(addr, addr_rslt0, vid_cfg_pkg::ADDR_OFF_ONES),
        hit(addr, addr_mult2, vid_cfg_pkg::ADDR_OFF_ONES),
        hit(addr, addr_mult1, vid_cfg_pkg::ADDR_OFF_ONES),
        addr == addr_id
    };

    // a new access only starts once the previous ack has dropped
    strobe_no_ack: assert property (@(posedge clk) disable iff (reg_rst) strobe |-> !ack);

endmodule

// ==== a_chip_regs.sv ====
// A chip register bank
`timescale 1ns/100ps

module a_chip_regs (
    input  logic                      clk,
    input  logic                      reg_rst,
    input  logic                      a_wr,
    input  vid_regs_pkg::reg_addr_t   addr,
    input  vid_regs_pkg::be_n_t       be_n,
    input  vid_regs_pkg::word_t       wdata,
    input  logic                      req_released,
    output vid_regs_pkg::word_t       vram_obj_base, vram1_base, vram2_base, vram3_base,
    output vid_regs_pkg::word_t       row_base, pal_base,
    output vid_regs_pkg::word_t       hpos1, vpos1, hpos2, vpos2, hpos3, vpos3,
    output vid_regs_pkg::word_t       hstar1, vstar1, hstar2, vstar2,
    output vid_regs_pkg::word_t       row_offset, ppu_ctrl,
    output logic                      pal_copy,
    output logic                      obj_dma_ok
);

    vid_regs_pkg::word_t regs_q [0:vid_regs_pkg::A_PPU_CTRL];
    logic                pend_copy;
    logic                pend_dma;

    // keep the old byte wherever its enable is high
    function automatic vid_regs_pkg::word_t merge(input vid_regs_pkg::word_t old_w,
                                                  input vid_regs_pkg::word_t new_w,
                                                  input vid_regs_pkg::be_n_t en_n);
        merge = {en_n[1] ? old_w[15:8] : new_w[15:8], en_n[0] ? old_w[7:0] : new_w[7:0]};
    endfunction

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            for (int i = 0; i <= int'(vid_regs_pkg::A_PPU_CTRL); i++) begin
                regs_q[i] <= '0;
            end
            pend_copy  <= 1'b0;
            pend_dma   <= 1'b0;
            pal_copy   <= 1'b0;
            obj_dma_ok <= 1'b0;
        end else begin
            // pulses wait for the cpu to release the bus so the base is settled
            pal_copy   <= pend_copy && req_released;
            obj_dma_ok <= pend_dma && req_released;
            if (req_released) begin
                pend_copy <= 1'b0;
                pend_dma  <= 1'b0;
            end
            if (a_wr && addr <= vid_regs_pkg::A_PPU_CTRL) begin
                regs_q[addr] <= merge(regs_q[addr], wdata, be_n);
                if (addr == vid_regs_pkg::A_PAL_BASE) pend_copy <= 1'b1;
                if (addr == vid_regs_pkg::A_VRAM_OBJ) pend_dma <= 1'b1;
            end
        end
    end

    assign vram_obj_base = regs_q[vid_regs_pkg::A_VRAM_OBJ];
    assign vram1_base    = regs_q[vid_regs_pkg::A_VRAM1];
    assign vram2_base    = regs_q[vid_regs_pkg::A_VRAM2];
    assign vram3_base    = regs_q[vid_regs_pkg::A_VRAM3];
    assign row_base      = regs_q[vid_regs_pkg::A_ROW_BASE];
    assign pal_base      = regs_q[vid_regs_pkg::A_PAL_BASE];
    assign hpos1         = regs_q[vid_regs_pkg::A_HPOS1];
    assign vpos1         = regs_q[vid_regs_pkg::A_VPOS1];
    assign hpos2         = regs_q[vid_regs_pkg::A_HPOS2];
    assign vpos2         = regs_q[vid_regs_pkg::A_VPOS2];
    assign hpos3         = regs_q[vid_regs_pkg::A_HPOS3];
    assign vpos3         = regs_q[vid_regs_pkg::A_VPOS3];
    assign hstar1        = regs_q[vid_regs_pkg::A_HSTAR1];
    assign vstar1        = regs_q[vid_regs_pkg::A_VSTAR1];
    assign hstar2        = regs_q[vid_regs_pkg::A_HSTAR2];
    assign vstar2        = regs_q[vid_regs_pkg::A_VSTAR2];
    assign row_offset    = regs_q[vid_regs_pkg::A_ROW_OFFSET];
    assign ppu_ctrl      = regs_q[vid_regs_pkg::A_PPU_CTRL];

endmodule

// ==== b_chip_regs.sv ====
// B chip registers and input ports
`timescale 1ns/100ps

module b_chip_regs (
    input  logic                      clk,
    input  logic                      reg_rst,
    input  logic                      b_wr,
    input  vid_cfg_pkg::b_sel_t       b_sel,
    input  vid_regs_pkg::be_n_t       be_n,
    input  vid_regs_pkg::word_t       wdata,
    input  logic                      six_button,
    input  logic [3:0]                start_button,
    input  logic [3:0]                coin_input,
    input  logic [9:0]                joystick1, joystick2, joystick3, joystick4,
    output vid_regs_pkg::word_t       mult1, mult2, rslt0, rslt1,
    output vid_regs_pkg::word_t       layer_ctrl, prio0, prio1, prio2, prio3,
    output logic [5:0]                pal_page_en,
    output vid_regs_pkg::in_port_t    in2, in3
);

    logic full_wr;

    // partial writes are ignored on this chip
    assign full_wr = b_wr && (be_n == 2'b00);

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mult1       <= '0;
            mult2       <= '0;
            layer_ctrl  <= vid_regs_pkg::LAYER_CTRL_RST;
            prio0       <= '0;
            prio1       <= '0;
            prio2       <= '0;
            prio3       <= '0;
            pal_page_en <= vid_regs_pkg::PAL_PAGE_RST;
        end else if (full_wr) begin
            if (b_sel[1])  mult1       <= wdata;
            if (b_sel[2])  mult2       <= wdata;
            if (b_sel[5])  layer_ctrl  <= wdata;
            if (b_sel[6])  prio0       <= wdata;
            if (b_sel[7])  prio1       <= wdata;
            if (b_sel[8])  prio2       <= wdata;
            if (b_sel[9])  prio3       <= wdata;
            if (b_sel[10]) pal_page_en <= wdata[5:0];
        end
    end

    // product lands one edge after a factor changes
    always_ff @(posedge clk) begin
        {rslt1, rslt0} <= mult1 * mult2;
    end

    // player inputs sampled every cycle
    always_ff @(posedge clk) begin
        in3 <= {start_button[3], coin_input[3], joystick4[5:0]};
        if (six_button) begin
            // extra buttons of players 1 and 2
            in2 <= {1'b1, joystick2[9:7], 1'b1, joystick1[9:7]};
        end else begin
            in2 <= {start_button[2], coin_input[2], joystick3[5:0]};
        end
    end

endmodule

// ==== read_mux.sv ====
// Read data selection
`timescale 1ns/100ps

module read_mux (
    input  logic                      clk,
    input  logic                      reg_rst,
    input  logic                      strobe,
    input  logic                      chip,
    input  logic                      b_wr,
    input  vid_cfg_pkg::b_sel_t       b_sel,
    input  vid_regs_pkg::in_port_t    cpsb_id,
    input  vid_regs_pkg::word_t       mult1, mult2, rslt0, rslt1,
    input  vid_regs_pkg::word_t       layer_ctrl, prio0, prio1, prio2, prio3,
    input  logic [5:0]                pal_page_en,
    input  vid_regs_pkg::in_port_t    in2, in3,
    output vid_regs_pkg::word_t       rdata
);

    vid_regs_pkg::word_t sel_data;

    always_comb begin
        case (1'b1)
            // id is stored packed, one nibble per byte on the bus
            b_sel[0]:  sel_data = {4'd0, cpsb_id[7:4], 4'd0, cpsb_id[3:0]};
            b_sel[1]:  sel_data = mult1;
            b_sel[2]:  sel_data = mult2;
            b_sel[3]:  sel_data = rslt0;
            b_sel[4]:  sel_data = rslt1;
            b_sel[5]:  sel_data = layer_ctrl;
            b_sel[6]:  sel_data = prio0;
            b_sel[7]:  sel_data = prio1;
            b_sel[8]:  sel_data = prio2;
            b_sel[9]:  sel_data = prio3;
            b_sel[10]: sel_data = {10'd0, pal_page_en};
            b_sel[11]: sel_data = {in2, in2};
            b_sel[12]: sel_data = {in3, in3};
            default:   sel_data = vid_regs_pkg::IDLE_READ;
        endcase
    end

    // A chip and write accesses return all ones
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            rdata <= vid_regs_pkg::IDLE_READ;
        end else if (strobe) begin
            rdata <= (chip && !b_wr) ? sel_data : vid_regs_pkg::IDLE_READ;
        end
    end

endmodule

// ==== video_regs_top.sv ====
// Video register file
`timescale 1ns/100ps

module video_regs_top (
    input  logic                      clk,
    input  logic                      reg_rst,
    // cpu bus
    input  logic                      req,
    input  logic                      chip,
    input  vid_regs_pkg::reg_addr_t   addr,
    input  vid_regs_pkg::be_n_t       be_n,
    input  vid_regs_pkg::word_t       wdata,
    output logic                      ack,
    output vid_regs_pkg::word_t       rdata,
    // game configuration
    input  logic                      cfg_we,
    input  vid_regs_pkg::in_port_t    cfg_data,
    // player inputs
    input  logic [3:0]                start_button,
    input  logic [3:0]                coin_input,
    input  logic [9:0]                joystick1, joystick2, joystick3, joystick4,
    // A chip
    output vid_regs_pkg::word_t       vram_obj_base, vram1_base, vram2_base, vram3_base,
    output vid_regs_pkg::word_t       row_base, pal_base,
    output vid_regs_pkg::word_t       hpos1, vpos1, hpos2, vpos2, hpos3, vpos3,
    output vid_regs_pkg::word_t       hstar1, vstar1, hstar2, vstar2,
    output vid_regs_pkg::word_t       row_offset, ppu_ctrl,
    output logic                      pal_copy,
    output logic                      obj_dma_ok,
    // B chip
    output vid_regs_pkg::word_t       layer_ctrl, prio0, prio1, prio2, prio3,
    output logic [5:0]                pal_page_en
);

    vid_regs_pkg::reg_addr_t addr_id, addr_mult1, addr_mult2, addr_rslt0, addr_rslt1;
    vid_regs_pkg::reg_addr_t addr_layer, addr_prio0, addr_prio1, addr_prio2, addr_prio3;
    vid_regs_pkg::reg_addr_t addr_pal_page, addr_in2, addr_in3;
    vid_regs_pkg::in_port_t  cpsb_id, in2, in3;
    vid_regs_pkg::word_t     mult1, mult2, rslt0, rslt1;
    vid_cfg_pkg::b_sel_t     b_sel;
    logic                    six_button, busy, strobe, a_wr, b_wr, req_released;

    // bus is busy from req until ack has dropped
    assign busy = req | ack;

    cfg_shift cfg_shift_i (.*);

    bus_decode bus_decode_i (.*);

    a_chip_regs a_chip_regs_i (.*);

    b_chip_regs b_chip_regs_i (.*);

    read_mux read_mux_i (.*);

endmodule

// ==== tb_clock.sv ====
// Testbench clock
`timescale 1ns/100ps

module tb_clock (
    output logic clk
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule

// ==== video_regs_tb.sv ====
// Video register file testbench
`timescale 1ns/100ps

module video_regs_tb;

    localparam int CLK_PERIOD_NS = 100;
    localparam int RESET_CYCLES = 16;
    // about 110 bus accesses in the tests, each allowed 20 cycles
    localparam int ACCESSES = 120;
    localparam int ACCESS_CYCLES = 20;
    localparam int WATCHDOG_NS = (RESET_CYCLES + 4 * vid_cfg_pkg::CFG_BYTES
                                  + ACCESSES * ACCESS_CYCLES) * CLK_PERIOD_NS;

    logic                       clk;
    logic                       reg_rst;
    logic                       req;
    logic                       chip;
    logic                       cfg_we;
    logic                       ack;
    logic                       pal_copy;
    logic                       obj_dma_ok;
    vid_regs_pkg::reg_addr_t    addr;
    vid_regs_pkg::be_n_t        be_n;
    vid_regs_pkg::word_t        wdata;
    vid_regs_pkg::word_t        rdata;
    vid_regs_pkg::word_t        layer_ctrl, prio0, prio1, prio2, prio3;
    vid_regs_pkg::word_t [17:0] a_out;
    vid_regs_pkg::word_t        a_model [18];
    vid_regs_pkg::in_port_t     cfg_data;
    logic [3:0]                 start_button, coin_input;
    logic [9:0]                 joystick1, joystick2, joystick3, joystick4;
    logic [5:0]                 pal_page_en;
    integer                     seed = 32'hbb57_bcfa;
    int                         errors = 0;
    int                         checks = 0;

    tb_clock tb_clock_i (.clk(clk));

    video_regs_top video_regs_top_i (
        .clk, .reg_rst, .req, .chip, .addr, .be_n, .wdata, .ack, .rdata,
        .cfg_we, .cfg_data, .start_button, .coin_input,
        .joystick1, .joystick2, .joystick3, .joystick4,
        .vram_obj_base(a_out[0]), .vram1_base(a_out[1]), .vram2_base(a_out[2]),
        .vram3_base(a_out[3]), .row_base(a_out[4]), .pal_base(a_out[5]),
        .hpos1(a_out[6]), .vpos1(a_out[7]), .hpos2(a_out[8]), .vpos2(a_out[9]),
        .hpos3(a_out[10]), .vpos3(a_out[11]), .hstar1(a_out[12]), .vstar1(a_out[13]),
        .hstar2(a_out[14]), .vstar2(a_out[15]), .row_offset(a_out[16]), .ppu_ctrl(a_out[17]),
        .pal_copy, .obj_dma_ok, .layer_ctrl, .prio0, .prio1, .prio2, .prio3, .pal_page_en
    );

    function automatic vid_regs_pkg::word_t rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    task automatic check_word(input string name, input vid_regs_pkg::word_t got,
                              input vid_regs_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // everything is driven and sampled 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic bus_access(input logic c, input vid_regs_pkg::reg_addr_t a,
                              input vid_regs_pkg::be_n_t b, input vid_regs_pkg::word_t d,
                              output vid_regs_pkg::word_t rd);
        int   n;
        logic exp_copy;
        logic exp_dma;
        exp_copy = !c && (b != 2'b11) && (a == 5'h05);
        exp_dma = !c && (b != 2'b11) && (a == 5'h00);
        req = 1'b1;
        chip = c;
        addr = a;
        be_n = b;
        wdata = d;
        n = 0;
        while (!ack && n < ACCESS_CYCLES) begin
            next_cycle();
            n++;
        end
        if (!ack) begin
            errors++;
            $display("ack never rose for the access to address %h at %0t", a, $time);
        end
        rd = rdata;
        check_word("pal_copy", {15'd0, pal_copy}, 16'd0);
        check_word("obj_dma_ok", {15'd0, obj_dma_ok}, 16'd0);
        req = 1'b0;
        n = 0;
        while (ack && n < ACCESS_CYCLES) begin
            next_cycle();
            n++;
        end
        if (ack) begin
            errors++;
            $display("ack stayed high after req dropped at %0t", $time);
        end
        // pulse starts at the edge where ack falls and lasts one cycle
        check_word("pal_copy", {15'd0, pal_copy}, {15'd0, exp_copy});
        check_word("obj_dma_ok", {15'd0, obj_dma_ok}, {15'd0, exp_dma});
        next_cycle();
        check_word("pal_copy", {15'd0, pal_copy}, 16'd0);
        check_word("obj_dma_ok", {15'd0, obj_dma_ok}, 16'd0);
    endtask

    task automatic bus_write(input logic c, input vid_regs_pkg::reg_addr_t a,
                             input vid_regs_pkg::be_n_t b, input vid_regs_pkg::word_t d);
        vid_regs_pkg::word_t rd;
        bus_access(c, a, b, d, rd);
    endtask

    task automatic bus_read(input logic c, input vid_regs_pkg::reg_addr_t a,
                            input vid_regs_pkg::word_t exp, input string name);
        vid_regs_pkg::word_t rd;
        bus_access(c, a, 2'b11, rand_word(), rd);
        check_word(name, rd, exp);
    endtask

    // B map: id 0x20, mult 0x02 0x04, results 0x06 0x08, layer 0x0A, prio 0x0C..
    task automatic load_cfg(input logic six);
        vid_regs_pkg::in_port_t bytes [vid_cfg_pkg::CFG_BYTES];
        bytes = '{8'h20, 8'h45, 8'h02, 8'h04, 8'h06, 8'h08, 8'h0A,
                  8'h0C, 8'h0E, 8'h10, 8'h3E, 8'h12, 8'h14, 8'h16};
        // bit 7 of the in2 byte picks the six button layout
        if (six) bytes[vid_cfg_pkg::CFG_IN2] = 8'h94;
        for (int i = 0; i < vid_cfg_pkg::CFG_BYTES; i++) begin
            cfg_we = 1'b1;
            cfg_data = bytes[i];
            next_cycle();
        end
        cfg_we = 1'b0;
    endtask

    task automatic reset_values();
        check_word("layer_ctrl", layer_ctrl, 16'h0E40);
        check_word("pal_page_en", {10'd0, pal_page_en}, 16'h003F);
        check_word("rdata", rdata, 16'hFFFF);
        check_word("ack", {15'd0, ack}, 16'd0);
        check_word("pal_copy", {15'd0, pal_copy}, 16'd0);
        check_word("obj_dma_ok", {15'd0, obj_dma_ok}, 16'd0);
    endtask

    task automatic a_chip_writes();
        vid_regs_pkg::word_t d;
        for (int off = 0; off < 18; off++) begin
            // be_n 0 comes first so the model starts from a full word
            for (int b = 0; b < 4; b++) begin
                d = rand_word();
                if (b == 3) begin
                    bus_read(1'b0, 5'(off), 16'hFFFF, "rdata");
                end else begin
                    bus_write(1'b0, 5'(off), 2'(b), d);
                    if (!b[1]) a_model[off][15:8] = d[15:8];
                    if (!b[0]) a_model[off][7:0] = d[7:0];
                end
                check_word($sformatf("a_out[%0d]", off), a_out[off], a_model[off]);
            end
        end
    endtask

    task automatic b_chip_map();
        vid_regs_pkg::word_t d;
        vid_regs_pkg::word_t layer_val;
        bus_read(1'b1, 5'h10, 16'h0405, "rdata id");
        bus_read(1'b1, 5'h09, 16'h003F, "rdata pal_page");
        // layer_ctrl then prio0 to prio2 at word addresses 5 to 8
        for (int i = 5; i <= 8; i++) begin
            d = rand_word();
            if (i == 5) layer_val = d;
            bus_write(1'b1, 5'(i), 2'b00, d);
            case (i)
                5: check_word("layer_ctrl", layer_ctrl, d);
                6: check_word("prio0", prio0, d);
                7: check_word("prio1", prio1, d);
                default: check_word("prio2", prio2, d);
            endcase
            bus_read(1'b1, 5'(i), d, $sformatf("rdata word %0d", i));
        end
        bus_write(1'b1, 5'h05, 2'b10, rand_word());
        check_word("layer_ctrl", layer_ctrl, layer_val);
        // prio3 is disabled, so it keeps its reset value
        bus_write(1'b1, 5'h1F, 2'b00, rand_word());
        check_word("prio3", prio3, 16'h0000);
        bus_read(1'b1, 5'h1F, 16'hFFFF, "rdata");
        bus_read(1'b1, 5'h1C, 16'hFFFF, "rdata");
    endtask

    task automatic multiplier();
        vid_regs_pkg::word_t m1;
        vid_regs_pkg::word_t m2;
        logic [31:0]         prod;
        for (int t = 0; t < 3; t++) begin
            m1 = rand_word();
            m2 = rand_word();
            prod = {16'd0, m1} * {16'd0, m2};
            bus_write(1'b1, 5'h01, 2'b00, m1);
            bus_write(1'b1, 5'h02, 2'b00, m2);
            bus_read(1'b1, 5'h03, prod[15:0], "rdata rslt0");
            bus_read(1'b1, 5'h04, prod[31:16], "rdata rslt1");
        end
    endtask

    // pulse expectations live in bus_access
    task automatic trigger_pulses();
        bus_write(1'b0, 5'h05, 2'b00, rand_word());
        bus_write(1'b0, 5'h00, 2'b01, rand_word());
        bus_write(1'b0, 5'h06, 2'b00, rand_word());
        bus_write(1'b1, 5'h06, 2'b00, rand_word());
    endtask

    task automatic input_ports(input logic six);
        logic [31:0]            r;
        vid_regs_pkg::in_port_t exp2;
        vid_regs_pkg::in_port_t exp3;
        for (int t = 0; t < 2; t++) begin
            r = $random(seed);
            start_button = r[3:0];
            coin_input = r[7:4];
            joystick1 = r[17:8];
            joystick2 = r[27:18];
            r = $random(seed);
            joystick3 = r[9:0];
            joystick4 = r[19:10];
            if (six) begin
                exp2 = {1'b1, joystick2[9:7], 1'b1, joystick1[9:7]};
            end else begin
                exp2 = {start_button[2], coin_input[2], joystick3[5:0]};
            end
            exp3 = {start_button[3], coin_input[3], joystick4[5:0]};
            next_cycle();
            bus_read(1'b1, 5'h0A, {exp2, exp2}, "rdata in2");
            bus_read(1'b1, 5'h0B, {exp3, exp3}, "rdata in3");
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        reg_rst = 1'b1;
        req = 1'b0;
        chip = 1'b0;
        addr = '0;
        be_n = 2'b11;
        wdata = '0;
        cfg_we = 1'b0;
        cfg_data = '0;
        start_button = '0;
        coin_input = '0;
        joystick1 = '0;
        joystick2 = '0;
        joystick3 = '0;
        joystick4 = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        reg_rst = 1'b0;
        next_cycle();
        reset_values();
        load_cfg(1'b0);
        a_chip_writes();
        b_chip_map();
        multiplier();
        trigger_pulses();
        input_ports(1'b0);
        load_cfg(1'b1);
        input_ports(1'b1);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
vid_regs_pkg.sv
vid_cfg_pkg.sv
cfg_shift.sv
bus_decode.sv
a_chip_regs.sv
b_chip_regs.sv
read_mux.sv
video_regs_top.sv
tb_clock.sv
video_regs_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the video register testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module video_regs_tb -Mdir obj_dir -f sim.f \
    && ./obj_dir/Vvideo_regs_tb > sim.log 2>&1
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
